// File: rtl/core_pkg.sv
// Shared RV32 pipeline definitions
// Only ADD, ADDI, LW and SW are decoded, every other word runs as a no-op
package core_pkg;

  // ========================================
  // Widths and register file
  // ========================================
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NUM_REGS   = 32;

  // ADDI x0, x0, 0
  localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

  // RV32 major opcodes in use
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [2:0] {
    INSTR_NOP,
    INSTR_ADD,
    INSTR_ADDI,
    INSTR_LW,
    INSTR_SW
  } instr_e;

  // Listed in falling priority
  typedef enum logic [1:0] {
    NO_STALL,
    MEM_STALL,
    FETCH_STALL,
    LOAD_RAW_STALL
  } stall_e;

  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_MEM,
    FWD_WB
  } fwd_e;

  // Kinds that write rd
  function automatic logic writes_rd(instr_e kind);
    return kind inside {INSTR_ADD, INSTR_ADDI, INSTR_LW};
  endfunction

endpackage

// File: rtl/mem_pkg.sv
// External bus definitions
// One request outstanding at a time, rvalid answers reads and writes alike
package mem_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Bus owner
  typedef enum logic {
    REQ_FETCH,
    REQ_LSU
  } requester_e;

  typedef enum logic {
    MEM_READ,
    MEM_WRITE
  } mem_op_e;

endpackage

// File: rtl/fetch_unit.sv
`timescale 1ns/1ps
// At most one fetch in flight; the PC only steps by 4, there are no branches
module fetch_unit
  import core_pkg::*, mem_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              advance_i,
  output logic              if_req_o,
  output logic [ADDR_W-1:0] if_addr_o,
  input  logic              if_rvalid_i,
  input  logic [DATA_W-1:0] if_rdata_i,
  output logic [XLEN-1:0]   instr_o,
  output logic [XLEN-1:0]   pc_o,
  output logic              if_valid_o
);

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] instr_q;
  logic            valid_q;
  logic            accept;

  // Decode takes the held word this cycle
  assign accept = valid_q & advance_i;

  // Level stays up while nothing is held, quiet during reset
  // Next fetch leaves in the accept cycle itself, at PC + 4
  assign if_req_o  = rst_ni && (!valid_q || accept);
  assign if_addr_o = accept ? pc_q + XLEN'(4) : pc_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pc_q    <= '0;
      valid_q <= 1'b0;
    end else begin
      if (if_rvalid_i) begin
        valid_q <= 1'b1;
      end else if (accept) begin
        valid_q <= 1'b0;
        pc_q    <= pc_q + XLEN'(4);
      end
    end
  end

  // Fetched word
  always_ff @(posedge clk_i) begin
    if (if_rvalid_i) begin
      instr_q <= if_rdata_i;
    end
  end

  // Bubble word while the fetch is still out
  assign instr_o    = valid_q ? instr_q : NOP_INSTR;
  assign pc_o       = pc_q;
  assign if_valid_o = valid_q;

  // Request is never withdrawn before its response
  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    if_req_o && !if_rvalid_i |=> if_req_o);

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
// Register file reads are write-first; x0 is never stored and reads as zero
module decode_stage
  import core_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [XLEN-1:0]       instr_i,
  input  logic                  wb_en_i,
  input  logic [REG_ADDR_W-1:0] wb_addr_i,
  input  logic [XLEN-1:0]       wb_data_i,
  output instr_e                instr_kind_o,
  output logic [REG_ADDR_W-1:0] rs1_addr_o,
  output logic [REG_ADDR_W-1:0] rs2_addr_o,
  output logic [REG_ADDR_W-1:0] rd_addr_o,
  output logic [XLEN-1:0]       rs1_data_o,
  output logic [XLEN-1:0]       rs2_data_o,
  output logic [XLEN-1:0]       imm_o
);

  logic [XLEN-1:0] rf_q [NUM_REGS];
  logic [2:0]      funct3;
  logic [6:0]      funct7;

  // ========================================
  // Instruction decode
  // ========================================
  assign funct3     = instr_i[14:12];
  assign funct7     = instr_i[31:25];
  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];

  always_comb begin
    instr_kind_o = INSTR_NOP;
    case (opcode_e'(instr_i[6:0]))
      OPC_OP: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
          instr_kind_o = INSTR_ADD;
        end
      end
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin
          instr_kind_o = INSTR_ADDI;
        end
      end
      OPC_LOAD: begin
        if (funct3 == 3'b010) begin
          instr_kind_o = INSTR_LW;
        end
      end
      OPC_STORE: begin
        if (funct3 == 3'b010) begin
          instr_kind_o = INSTR_SW;
        end
      end
      default: instr_kind_o = INSTR_NOP;
    endcase
  end

  // S-type splits the offset, I-type keeps it in the top bits
  assign imm_o = (instr_kind_o == INSTR_SW) ?
                 {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]} :
                 {{20{instr_i[31]}}, instr_i[31:20]};

  // rd field of a store is offset bits
  assign rd_addr_o = writes_rd(instr_kind_o) ? instr_i[11:7] : '0;

  // ========================================
  // Register file
  // ========================================
  always_ff @(posedge clk_i) begin
    if (wb_en_i && wb_addr_i != '0) begin
      rf_q[wb_addr_i] <= wb_data_i;
    end
  end

  // Same-cycle writeback bypass
  assign rs1_data_o = (rs1_addr_o == '0) ? '0 :
                      (wb_en_i && wb_addr_i == rs1_addr_o) ? wb_data_i : rf_q[rs1_addr_o];
  assign rs2_data_o = (rs2_addr_o == '0) ? '0 :
                      (wb_en_i && wb_addr_i == rs2_addr_o) ? wb_data_i : rf_q[rs2_addr_o];

  // Values written into the array are always known
  a_wb_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_en_i && wb_addr_i != '0 |-> !$isunknown(wb_data_i));

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps
// Single adder serves ADD, ADDI and the LW/SW effective address
module execute_stage
  import core_pkg::*;
(
  input  instr_e          instr_kind_i,
  input  logic [XLEN-1:0] rs1_data_i,
  input  logic [XLEN-1:0] rs2_data_i,
  input  logic [XLEN-1:0] imm_i,
  input  fwd_e            fwd_a_i,
  input  fwd_e            fwd_b_i,
  input  logic [XLEN-1:0] mem_result_i,
  input  logic [XLEN-1:0] wb_data_i,
  output logic [XLEN-1:0] result_o,
  output logic [XLEN-1:0] store_data_o
);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] addend;

  // Forwarding muxes
  always_comb begin
    case (fwd_a_i)
      FWD_MEM: op_a = mem_result_i;
      FWD_WB:  op_a = wb_data_i;
      default: op_a = rs1_data_i;
    endcase
    case (fwd_b_i)
      FWD_MEM: op_b = mem_result_i;
      FWD_WB:  op_b = wb_data_i;
      default: op_b = rs2_data_i;
    endcase
  end

  // Only ADD takes rs2 as the second addend
  assign addend = (instr_kind_i == INSTR_ADD) ? op_b : imm_i;

  assign result_o = op_a + addend;

  // SW data is the forwarded rs2
  assign store_data_o = op_b;

endmodule

// File: rtl/load_store_unit.sv
`timescale 1ns/1ps
// Word accesses only; one access per memory-stage instruction, even when frozen
module load_store_unit
  import core_pkg::*, mem_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              advance_i,
  input  instr_e            instr_kind_i,
  input  logic [XLEN-1:0]   addr_i,
  input  logic [XLEN-1:0]   store_data_i,
  output logic              ls_req_o,
  output mem_op_e           ls_op_o,
  output logic [ADDR_W-1:0] ls_addr_o,
  output logic [DATA_W-1:0] ls_wdata_o,
  input  logic              ls_rvalid_i,
  input  logic [DATA_W-1:0] ls_rdata_i,
  output logic [XLEN-1:0]   load_data_o,
  output logic              busy_o
);

  logic            is_mem;
  logic            done_q;
  logic [XLEN-1:0] load_q;

  assign is_mem = instr_kind_i inside {INSTR_LW, INSTR_SW};

  // Busy from the request until the response cycle
  assign busy_o = is_mem & !done_q;

  assign ls_req_o   = busy_o;
  assign ls_op_o    = (instr_kind_i == INSTR_SW) ? MEM_WRITE : MEM_READ;
  assign ls_addr_o  = addr_i;
  assign ls_wdata_o = store_data_i;

  // Finished access, kept until the stage moves on
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else if (advance_i) begin
      done_q <= 1'b0;
    end else if (ls_rvalid_i) begin
      done_q <= 1'b1;
    end
  end

  // Load word held for the MEM/WB register
  always_ff @(posedge clk_i) begin
    if (ls_rvalid_i && ls_op_o == MEM_READ) begin
      load_q <= ls_rdata_i;
    end
  end

  assign load_data_o = load_q;

endmodule

// File: rtl/memory_arbiter.sv
`timescale 1ns/1ps
// LSU wins over fetch on an idle bus; the owner keeps the bus until its rvalid
module memory_arbiter
  import mem_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              if_req_i,
  input  logic [ADDR_W-1:0] if_addr_i,
  output logic              if_rvalid_o,
  output logic [DATA_W-1:0] if_rdata_o,
  input  logic              ls_req_i,
  input  mem_op_e           ls_op_i,
  input  logic [ADDR_W-1:0] ls_addr_i,
  input  logic [DATA_W-1:0] ls_wdata_i,
  output logic              ls_rvalid_o,
  output logic [DATA_W-1:0] ls_rdata_o,
  output logic              mem_req_o,
  output mem_op_e           mem_op_o,
  output logic [ADDR_W-1:0] mem_addr_o,
  output logic [DATA_W-1:0] mem_wdata_o,
  input  logic              mem_rvalid_i,
  input  logic [DATA_W-1:0] mem_rdata_i
);

  logic       busy_q;
  requester_e owner_q;
  requester_e winner;

  assign winner = ls_req_i ? REQ_LSU : REQ_FETCH;

  // One pulse per grant, only on an idle bus
  assign mem_req_o   = !busy_q && (ls_req_i || if_req_i);
  assign mem_op_o    = (winner == REQ_LSU) ? ls_op_i : MEM_READ;
  assign mem_addr_o  = (winner == REQ_LSU) ? ls_addr_i : if_addr_i;
  assign mem_wdata_o = ls_wdata_i;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      owner_q <= REQ_FETCH;
    end else if (mem_req_o) begin
      busy_q  <= 1'b1;
      owner_q <= winner;
    end else if (mem_rvalid_i) begin
      busy_q <= 1'b0;
    end
  end

  // Response goes back to the owner only
  assign if_rvalid_o = mem_rvalid_i && busy_q && owner_q == REQ_FETCH;
  assign ls_rvalid_o = mem_rvalid_i && busy_q && owner_q == REQ_LSU;
  assign if_rdata_o  = (owner_q == REQ_FETCH) ? mem_rdata_i : '0;
  assign ls_rdata_o  = (owner_q == REQ_LSU) ? mem_rdata_i : '0;

  // Memory answers only an outstanding request
  a_rvalid_owned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rvalid_i |-> busy_q);

endmodule

// File: rtl/hazard_unit.sv
`timescale 1ns/1ps
// Register x0 never forwards and never causes a load-use stall
module hazard_unit
  import core_pkg::*;
(
  input  logic [REG_ADDR_W-1:0] rs1_addr_de_i,
  input  logic [REG_ADDR_W-1:0] rs2_addr_de_i,
  input  logic [REG_ADDR_W-1:0] rs1_addr_ex_i,
  input  logic [REG_ADDR_W-1:0] rs2_addr_ex_i,
  input  logic [REG_ADDR_W-1:0] rd_addr_ex_i,
  input  logic                  is_load_ex_i,
  input  logic [REG_ADDR_W-1:0] rd_addr_me_i,
  input  logic                  rf_we_me_i,
  input  logic [REG_ADDR_W-1:0] rd_addr_wb_i,
  input  logic                  rf_we_wb_i,
  output fwd_e                  fwd_a_o,
  output fwd_e                  fwd_b_o,
  output logic                  load_use_o
);

  // Youngest producer wins, so memory stage before writeback
  function automatic fwd_e fwd_sel(logic [REG_ADDR_W-1:0] rs);
    fwd_e sel;
    sel = FWD_NONE;
    if (rs != '0) begin
      if (rf_we_me_i && rd_addr_me_i == rs) begin
        sel = FWD_MEM;
      end else if (rf_we_wb_i && rd_addr_wb_i == rs) begin
        sel = FWD_WB;
      end
    end
    return sel;
  endfunction

  assign fwd_a_o = fwd_sel(rs1_addr_ex_i);
  assign fwd_b_o = fwd_sel(rs2_addr_ex_i);

  // LW result is not ready until writeback
  assign load_use_o = is_load_ex_i && rd_addr_ex_i != '0 &&
                      (rd_addr_ex_i == rs1_addr_de_i || rd_addr_ex_i == rs2_addr_de_i);

endmodule

// File: rtl/rv_core.sv
`timescale 1ns/1ps
// In-order RV32 core, ADD/ADDI/LW/SW only, no branches or traps
// Fetch and load/store share one strobe bus through the arbiter
module rv_core
  import core_pkg::*, mem_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  output logic              mem_req_o,
  output mem_op_e           mem_op_o,
  output logic [ADDR_W-1:0] mem_addr_o,
  output logic [DATA_W-1:0] mem_wdata_o,
  input  logic              mem_rvalid_i,
  input  logic [DATA_W-1:0] mem_rdata_i
);

  stall_e stall_cause;
  logic   freeze;

  // Fetch side
  logic              if_req;
  logic [ADDR_W-1:0] if_addr;
  logic              if_rvalid;
  logic [DATA_W-1:0] if_rdata;
  logic [XLEN-1:0]   fe_instr;
  logic              if_valid;

  // Decode outputs
  instr_e                de_kind;
  logic [REG_ADDR_W-1:0] de_rs1_addr;
  logic [REG_ADDR_W-1:0] de_rs2_addr;
  logic [REG_ADDR_W-1:0] de_rd_addr;
  logic [XLEN-1:0]       de_rs1_data;
  logic [XLEN-1:0]       de_rs2_data;
  logic [XLEN-1:0]       de_imm;

  // ID/EX
  instr_e                kind_ex;
  logic [REG_ADDR_W-1:0] rs1_addr_ex;
  logic [REG_ADDR_W-1:0] rs2_addr_ex;
  logic [REG_ADDR_W-1:0] rd_addr_ex;
  logic [XLEN-1:0]       rs1_data_ex;
  logic [XLEN-1:0]       rs2_data_ex;
  logic [XLEN-1:0]       imm_ex;
  fwd_e                  fwd_a;
  fwd_e                  fwd_b;
  logic [XLEN-1:0]       ex_result;
  logic [XLEN-1:0]       ex_store_data;
  logic                  load_use;

  // EX/MEM
  instr_e                kind_me;
  logic [REG_ADDR_W-1:0] rd_addr_me;
  logic [XLEN-1:0]       result_me;
  logic [XLEN-1:0]       store_data_me;
  logic                  ls_req;
  mem_op_e               ls_op;
  logic [ADDR_W-1:0]     ls_addr;
  logic [DATA_W-1:0]     ls_wdata;
  logic                  ls_rvalid;
  logic [DATA_W-1:0]     ls_rdata;
  logic [XLEN-1:0]       me_load_data;
  logic                  lsu_busy;

  // MEM/WB
  instr_e                kind_wb;
  logic [REG_ADDR_W-1:0] rd_addr_wb;
  logic [XLEN-1:0]       result_wb;
  logic [XLEN-1:0]       load_data_wb;
  logic [XLEN-1:0]       wb_data;

  // ========================================
  // Stall priority
  // ========================================
  always_comb begin
    if (lsu_busy) begin
      stall_cause = MEM_STALL;
    end else if (!if_valid) begin
      stall_cause = FETCH_STALL;
    end else if (load_use) begin
      stall_cause = LOAD_RAW_STALL;
    end else begin
      stall_cause = NO_STALL;
    end
  end

  // Bus waits hold every stage
  assign freeze = stall_cause inside {MEM_STALL, FETCH_STALL};

  // ========================================
  // Fetch and decode
  // ========================================
  fetch_unit u_fetch (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .advance_i   (stall_cause == NO_STALL),
    .if_req_o    (if_req),
    .if_addr_o   (if_addr),
    .if_rvalid_i (if_rvalid),
    .if_rdata_i  (if_rdata),
    .instr_o     (fe_instr),
    .pc_o        (),
    .if_valid_o  (if_valid)
  );

  decode_stage u_decode (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .instr_i      (fe_instr),
    .wb_en_i      (writes_rd(kind_wb)),
    .wb_addr_i    (rd_addr_wb),
    .wb_data_i    (wb_data),
    .instr_kind_o (de_kind),
    .rs1_addr_o   (de_rs1_addr),
    .rs2_addr_o   (de_rs2_addr),
    .rd_addr_o    (de_rd_addr),
    .rs1_data_o   (de_rs1_data),
    .rs2_data_o   (de_rs2_data),
    .imm_o        (de_imm)
  );

  // ID/EX control, bubble on a load-use hit
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      kind_ex    <= INSTR_NOP;
      rd_addr_ex <= '0;
    end else if (!freeze) begin
      if (stall_cause == LOAD_RAW_STALL) begin
        kind_ex    <= INSTR_NOP;
        rd_addr_ex <= '0;
      end else begin
        kind_ex    <= de_kind;
        rd_addr_ex <= de_rd_addr;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!freeze) begin
      rs1_addr_ex <= de_rs1_addr;
      rs2_addr_ex <= de_rs2_addr;
      rs1_data_ex <= de_rs1_data;
      rs2_data_ex <= de_rs2_data;
      imm_ex      <= de_imm;
    end
  end

  // ========================================
  // Execute
  // ========================================
  execute_stage u_execute (
    .instr_kind_i (kind_ex),
    .rs1_data_i   (rs1_data_ex),
    .rs2_data_i   (rs2_data_ex),
    .imm_i        (imm_ex),
    .fwd_a_i      (fwd_a),
    .fwd_b_i      (fwd_b),
    .mem_result_i (result_me),
    .wb_data_i    (wb_data),
    .result_o     (ex_result),
    .store_data_o (ex_store_data)
  );

  hazard_unit u_hazard (
    .rs1_addr_de_i (de_rs1_addr),
    .rs2_addr_de_i (de_rs2_addr),
    .rs1_addr_ex_i (rs1_addr_ex),
    .rs2_addr_ex_i (rs2_addr_ex),
    .rd_addr_ex_i  (rd_addr_ex),
    .is_load_ex_i  (kind_ex == INSTR_LW),
    .rd_addr_me_i  (rd_addr_me),
    .rf_we_me_i    (writes_rd(kind_me)),
    .rd_addr_wb_i  (rd_addr_wb),
    .rf_we_wb_i    (writes_rd(kind_wb)),
    .fwd_a_o       (fwd_a),
    .fwd_b_o       (fwd_b),
    .load_use_o    (load_use)
  );

  // EX/MEM and MEM/WB control
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      kind_me    <= INSTR_NOP;
      rd_addr_me <= '0;
      kind_wb    <= INSTR_NOP;
      rd_addr_wb <= '0;
    end else if (!freeze) begin
      kind_me    <= kind_ex;
      rd_addr_me <= rd_addr_ex;
      kind_wb    <= kind_me;
      rd_addr_wb <= rd_addr_me;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!freeze) begin
      result_me     <= ex_result;
      store_data_me <= ex_store_data;
      result_wb     <= result_me;
      load_data_wb  <= me_load_data;
    end
  end

  // ========================================
  // Memory access and bus sharing
  // ========================================
  load_store_unit u_lsu (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .advance_i    (!freeze),
    .instr_kind_i (kind_me),
    .addr_i       (result_me),
    .store_data_i (store_data_me),
    .ls_req_o     (ls_req),
    .ls_op_o      (ls_op),
    .ls_addr_o    (ls_addr),
    .ls_wdata_o   (ls_wdata),
    .ls_rvalid_i  (ls_rvalid),
    .ls_rdata_i   (ls_rdata),
    .load_data_o  (me_load_data),
    .busy_o       (lsu_busy)
  );

  memory_arbiter u_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .if_req_i     (if_req),
    .if_addr_i    (if_addr),
    .if_rvalid_o  (if_rvalid),
    .if_rdata_o   (if_rdata),
    .ls_req_i     (ls_req),
    .ls_op_i      (ls_op),
    .ls_addr_i    (ls_addr),
    .ls_wdata_i   (ls_wdata),
    .ls_rvalid_o  (ls_rvalid),
    .ls_rdata_o   (ls_rdata),
    .mem_req_o    (mem_req_o),
    .mem_op_o     (mem_op_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i)
  );

  // Writeback picks the load word for LW
  assign wb_data = (kind_wb == INSTR_LW) ? load_data_wb : result_wb;

endmodule

// File: tb/tb_iss.svh
// Included inside the testbench module body; core_pkg must be imported there
// Program sits at address 0, data words from 0x400 up, all in one 1024-word image
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

localparam int unsigned PROG_LEN  = 64;
localparam int unsigned MEM_WORDS = 1024;
localparam logic [31:0] DATA_BASE = 32'h0000_0400;

logic [31:0] rng_state;
logic [31:0] image   [MEM_WORDS];
logic [31:0] iss_mem [MEM_WORDS];

// Generated program, one entry per instruction
instr_e      prog_kind [PROG_LEN];
logic [2:0]  prog_rd   [PROG_LEN];
logic [2:0]  prog_rs1  [PROG_LEN];
logic [2:0]  prog_rs2  [PROG_LEN];
logic [11:0] prog_imm  [PROG_LEN];

// Expected bus writes in program order
logic [31:0] exp_store_addr [$];
logic [31:0] exp_store_data [$];

// ========================================
// Random numbers and encodings
// ========================================
function automatic logic [31:0] xorshift(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

function automatic logic [31:0] next_rand();
  rng_state = xorshift(rng_state);
  return rng_state;
endfunction

// ADD rd, rs1, rs2
function automatic logic [31:0] r_type_word(logic [2:0] rd, logic [2:0] rs1, logic [2:0] rs2);
  return {7'b0000000, 2'b00, rs2, 2'b00, rs1, 3'b000, 2'b00, rd, OPC_OP};
endfunction

// ADDI and LW share the I layout
function automatic logic [31:0] i_type_word(opcode_e opc, logic [2:0] f3, logic [2:0] rd,
                                            logic [2:0] rs1, logic [11:0] imm);
  return {imm, 2'b00, rs1, f3, 2'b00, rd, opc};
endfunction

// SW rs2, imm(x0)
function automatic logic [31:0] s_type_word(logic [2:0] rs2, logic [11:0] imm);
  return {imm[11:5], 2'b00, rs2, 5'd0, 3'b010, imm[4:0], OPC_STORE};
endfunction

// ========================================
// Program generator
// ========================================
task automatic build_program();
  logic [31:0] r;
  logic [7:0]  didx;
  instr_e      kind;
  // Data fill carries its own byte address
  for (int w = 0; w < MEM_WORDS; w++) begin
    image[w] = (w < 256) ? NOP_INSTR : (32'hD00D_0000 | (32'(w) << 2));
  end
  for (int i = 0; i < PROG_LEN; i++) begin
    r = next_rand();
    prog_rd[i]  = r[2:0];
    prog_rs1[i] = r[5:3];
    prog_rs2[i] = r[8:6];
    prog_imm[i] = r[20:9];
    // Word slots at both ends of the data window
    didx = r[24] ? {5'b11111, r[23:21]} : {5'b00000, r[23:21]};
    case (r[26:25])
      2'd0:    kind = INSTR_ADD;
      2'd1:    kind = INSTR_ADDI;
      2'd2:    kind = INSTR_LW;
      default: kind = INSTR_SW;
    endcase
    // First seven set up x1..x7 so no register is read before it is written
    if (i < 7) begin
      kind        = INSTR_ADDI;
      prog_rd[i]  = 3'(i + 1);
      prog_rs1[i] = 3'd0;
    end
    if (kind == INSTR_LW || kind == INSTR_SW) begin
      prog_rs1[i] = 3'd0;
      prog_imm[i] = 12'h400 | {2'b00, didx, 2'b00};
    end
    prog_kind[i] = kind;
    case (kind)
      INSTR_ADD:  image[i] = r_type_word(prog_rd[i], prog_rs1[i], prog_rs2[i]);
      INSTR_ADDI: image[i] = i_type_word(OPC_OP_IMM, 3'b000, prog_rd[i], prog_rs1[i], prog_imm[i]);
      INSTR_LW:   image[i] = i_type_word(OPC_LOAD, 3'b010, prog_rd[i], 3'd0, prog_imm[i]);
      default:    image[i] = s_type_word(prog_rs2[i], prog_imm[i]);
    endcase
  end
endtask

// ========================================
// In-order instruction-set model
// ========================================
task automatic run_model();
  logic [31:0] regs [8];
  logic [31:0] sext;
  logic [9:0]  widx;
  for (int w = 0; w < MEM_WORDS; w++) begin
    iss_mem[w] = image[w];
  end
  for (int k = 0; k < 8; k++) begin
    regs[k] = '0;
  end
  for (int i = 0; i < PROG_LEN; i++) begin
    sext = {{20{prog_imm[i][11]}}, prog_imm[i]};
    widx = sext[11:2];
    case (prog_kind[i])
      INSTR_ADD:  regs[prog_rd[i]] = regs[prog_rs1[i]] + regs[prog_rs2[i]];
      INSTR_ADDI: regs[prog_rd[i]] = regs[prog_rs1[i]] + sext;
      INSTR_LW:   regs[prog_rd[i]] = iss_mem[widx];
      default: begin
        iss_mem[widx] = regs[prog_rs2[i]];
        exp_store_addr.push_back(sext);
        exp_store_data.push_back(regs[prog_rs2[i]]);
      end
    endcase
    // x0 is hard-wired
    regs[0] = '0;
  end
endtask

`endif

// File: tb/tb_rv_core.sv
`timescale 1ns/1ps
// Random ADD/ADDI/LW/SW program against an in-order model; bus answers in 1 to 4 cycles
// Addresses below 0x400 are taken as fetches, LW/SW only touch 0x400 and up
module tb_rv_core
  import core_pkg::*, mem_pkg::*;
();

  localparam logic [31:0] SEED        = 32'h185f;
  localparam int          FIRST_LIMIT = 1;
  localparam int          STORE_LIMIT = 5000;
  localparam int          TAIL_CYCLES = 200;

  logic              clk_i;
  logic              rst_ni;
  logic              mem_req_o;
  mem_op_e           mem_op_o;
  logic [ADDR_W-1:0] mem_addr_o;
  logic [DATA_W-1:0] mem_wdata_o;
  logic              mem_rvalid_i;
  logic [DATA_W-1:0] mem_rdata_i;

  // Responder state
  logic [31:0] bus_data [MEM_WORDS];
  logic        pending;
  int          delay_left;
  mem_op_e     pend_op;
  logic [31:0] pend_addr;
  logic [31:0] pend_wdata;
  logic        seen_first;
  logic [31:0] next_fetch;
  int          cycles;

  `include "tb_iss.svh"

  rv_core UUT (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mem_req_o    (mem_req_o),
    .mem_op_o     (mem_op_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i)
  );

  // ========================================
  // Failure reporting and compare tasks
  // ========================================
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "testbench stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    abort_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_store(input mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] data, input logic [31:0] exp_addr,
                             input logic [31:0] exp_data);
    if (op !== MEM_WRITE) begin
      report_mismatch("mem_op_o", 32'(op), 32'(MEM_WRITE));
    end else if (addr !== exp_addr) begin
      report_mismatch("mem_addr_o", addr, exp_addr);
    end else if (data !== exp_data) begin
      report_mismatch("mem_wdata_o", data, exp_data);
    end
  endtask

  task automatic check_fetch_addr(input mem_op_e op, input logic [31:0] addr,
                                  input logic [31:0] exp_addr);
    if (op !== MEM_READ) begin
      report_mismatch("mem_op_o", 32'(op), 32'(MEM_READ));
    end else if (addr !== exp_addr) begin
      report_mismatch("mem_addr_o", addr, exp_addr);
    end
  endtask

  task automatic check_idle(input string name, input logic value);
    if (value !== 1'b0) begin
      report_mismatch(name, 32'(value), 32'h0);
    end
  endtask

  // ========================================
  // Clock, bus monitor and responder
  // ========================================
  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #20 clk_i = ~clk_i;
    end
  end

  // Outputs are sampled mid-cycle, well clear of the drive edge
  initial begin : bus_monitor
    forever begin
      @(negedge clk_i);
      if (!rst_ni) begin
        check_idle("mem_req_o", mem_req_o);
      end else if (mem_req_o && (pending || mem_rvalid_i)) begin
        // Request while one is still out
        check_idle("mem_req_o", mem_req_o);
      end else if (mem_req_o) begin
        pending    = 1'b1;
        delay_left = int'(next_rand() & 32'd3);
        pend_op    = mem_op_o;
        pend_addr  = mem_addr_o;
        pend_wdata = mem_wdata_o;
        if (!seen_first || (mem_op_o == MEM_READ && mem_addr_o < DATA_BASE)) begin
          check_fetch_addr(mem_op_o, mem_addr_o, next_fetch);
          next_fetch = next_fetch + 32'd4;
          seen_first = 1'b1;
        end else if (mem_op_o == MEM_WRITE && exp_store_addr.size() == 0) begin
          abort_run("a store appeared after the last expected store");
        end else if (mem_op_o == MEM_WRITE) begin
          check_store(mem_op_o, mem_addr_o, mem_wdata_o,
                      exp_store_addr.pop_front(), exp_store_data.pop_front());
        end
      end
    end
  end

  // One-cycle rvalid after 1 to 4 cycles, for reads and writes alike
  initial begin : bus_responder
    forever begin
      @(posedge clk_i);
      #1;
      mem_rvalid_i = 1'b0;
      if (pending && delay_left == 0) begin
        mem_rvalid_i = 1'b1;
        pending      = 1'b0;
        if (pend_op == MEM_WRITE) begin
          bus_data[pend_addr[11:2]] = pend_wdata;
          mem_rdata_i               = '0;
        end else begin
          mem_rdata_i = bus_data[pend_addr[11:2]];
        end
      end else if (pending) begin
        delay_left = delay_left - 1;
      end
    end
  end

  // ========================================
  // Test sequence
  // ========================================
  initial begin : test_sequence
    rst_ni       = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    pending      = 1'b0;
    delay_left   = 0;
    seen_first   = 1'b0;
    next_fetch   = '0;
    rng_state    = SEED;
    build_program();
    run_model();
    for (int w = 0; w < MEM_WORDS; w++) begin
      bus_data[w] = image[w];
    end
    // Two reset cycles, released just after the edge
    repeat (2) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    // First fetch is due in the first cycle out of reset
    cycles = 0;
    while (!seen_first && cycles < FIRST_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    if (!seen_first) begin
      abort_run("no bus request in the first cycle after reset");
    end

    // Monitor pops each store as it shows up on the bus
    cycles = 0;
    while (exp_store_addr.size() != 0 && cycles < STORE_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    if (exp_store_addr.size() != 0) begin
      abort_run($sformatf("timed out with %0d expected stores never seen",
                          exp_store_addr.size()));
    end

    // Tail of no-ops, any further write fails in the monitor
    cycles = 0;
    while (cycles < TAIL_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("sim passed");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+tb
rtl/core_pkg.sv
rtl/mem_pkg.sv
rtl/fetch_unit.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/load_store_unit.sv
rtl/memory_arbiter.sv
rtl/hazard_unit.sv
rtl/rv_core.sv
tb/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and decide by the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module tb_rv_core -o tb_rv_core
./obj_dir/tb_rv_core > sim.log 2>&1 || true
cat sim.log
if grep -q "^sim passed$" sim.log; then
  exit 0
fi
exit 1
